// ==== flist.f ====
rtl/corePkg.sv
rtl/ctrlIf.sv
rtl/fetchUnit.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/executeUnit.sv
rtl/memStage.sv
rtl/core.sv
tests/core_assertions.sv
tests/coreTb.sv

// ==== rtl/core.sv ====
// Core top level connecting fetch, decode, register file, execute and memory units
`timescale 1ns/100ps

module core (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            imemWrEn,
    input  logic [corePkg::IMEM_ADDR_W-1:0] imemWrAddr,
    input  corePkg::wordT                   imemWrData,
    output corePkg::wordT                   printVal,
    output logic                            printEn
);

    corePkg::wordT    instruction;
    corePkg::wordT    pc;
    corePkg::wordT    pcPlus4;
    corePkg::wordT    nextPc;
    corePkg::wordT    aluResult;
    corePkg::wordT    wbData;
    corePkg::regAddrT rs1Addr;
    corePkg::regAddrT rs2Addr;
    corePkg::regAddrT rdAddr;

    ctrlIf ctrl ();

    fetchUnit uFetch (
        .CLK         (CLK),
        .RESET       (RESET),
        .imemWrEn    (imemWrEn),
        .imemWrAddr  (imemWrAddr),
        .imemWrData  (imemWrData),
        .nextPc      (nextPc),
        .pc          (pc),
        .pcPlus4     (pcPlus4),
        .instruction (instruction)
    );

    decoder uDecoder (
        .instruction (instruction),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .rdAddr      (rdAddr),
        .ctrl        (ctrl.decode)
    );

    regFile uRegFile (
        .CLK     (CLK),
        .RESET   (RESET),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (rdAddr),
        .wbData  (wbData),
        .ctrl    (ctrl.decode)
    );

    executeUnit uExecute (
        .pc        (pc),
        .pcPlus4   (pcPlus4),
        .ctrl      (ctrl.exec),
        .aluResult (aluResult),
        .nextPc    (nextPc)
    );

    memStage uMem (
        .CLK       (CLK),
        .RESET     (RESET),
        .aluResult (aluResult),
        .pcPlus4   (pcPlus4),
        .ctrl      (ctrl.mem),
        .wbData    (wbData),
        .printVal  (printVal),
        .printEn   (printEn)
    );

endmodule

// ==== rtl/corePkg.sv ====
// Core widths, memory sizes, fixed addresses and the enums for opcodes and control fields
package corePkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_DEPTH  = 256;
    localparam int DMEM_DEPTH  = 256;
    localparam int IMEM_ADDR_W = 8;  // Word index into imem
    localparam int DMEM_ADDR_W = 8;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0000;
    localparam logic [XLEN-1:0] PRINT_ADDR = 32'h0000_1030;  // Byte address, not a dmem word

    typedef logic [XLEN-1:0]       wordT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_COPY2  // Pass operand two through
    } aluOpE;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immTypeE;

    // Encoded as funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branchFuncE;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSrcE;

endpackage

// ==== rtl/ctrlIf.sv ====
// Interface carrying decoded control, immediate and register operands
`timescale 1ns/100ps

interface ctrlIf;
    corePkg::aluOpE      aluOp;
    logic                useRs1;     // ALU in1: rs1 or pc
    logic                useImm;     // ALU in2: imm or rs2
    logic                isJump;
    logic                isJumpReg;
    logic                isBranch;
    corePkg::branchFuncE branchFunc;
    logic                memRead;
    logic                memWrite;
    logic                regWrite;
    corePkg::wbSrcE      wbSrc;
    corePkg::wordT       imm;
    corePkg::wordT       rs1Data;
    corePkg::wordT       rs2Data;

    // Decoder drives control; regFile drives the operand data on the same side
    modport decode (output aluOp, useRs1, useImm, isJump, isJumpReg, isBranch, branchFunc,
                    memRead, memWrite, regWrite, wbSrc, imm, rs1Data, rs2Data);
    modport exec (input aluOp, useRs1, useImm, isJump, isJumpReg, isBranch, branchFunc,
                  imm, rs1Data, rs2Data);
    modport mem (input memRead, memWrite, wbSrc, rs2Data);
endinterface

// ==== rtl/decoder.sv ====
// Instruction decode into control fields, register indices and immediate
`timescale 1ns/100ps

module decoder (
    input  corePkg::wordT    instruction,
    output corePkg::regAddrT rs1Addr,
    output corePkg::regAddrT rs2Addr,
    output corePkg::regAddrT rdAddr,
    ctrlIf.decode            ctrl
);

    corePkg::opcodeE  opcode;
    corePkg::immTypeE immType;
    logic [2:0]       funct3;
    logic             funct7b5;

    // funct3 to ALU operation; alt selects SUB or SRA
    function automatic corePkg::aluOpE aluOpFor(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  aluOpFor = alt ? corePkg::ALU_SUB : corePkg::ALU_ADD;
            3'b001:  aluOpFor = corePkg::ALU_SLL;
            3'b010:  aluOpFor = corePkg::ALU_SLT;
            3'b011:  aluOpFor = corePkg::ALU_SLTU;
            3'b100:  aluOpFor = corePkg::ALU_XOR;
            3'b101:  aluOpFor = alt ? corePkg::ALU_SRA : corePkg::ALU_SRL;
            3'b110:  aluOpFor = corePkg::ALU_OR;
            default: aluOpFor = corePkg::ALU_AND;
        endcase
    endfunction

    assign opcode   = corePkg::opcodeE'(instruction[6:0]);
    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];
    assign rdAddr   = instruction[11:7];
    assign rs1Addr  = instruction[19:15];
    assign rs2Addr  = instruction[24:20];

    always_comb begin
        ctrl.aluOp      = corePkg::ALU_ADD;
        ctrl.useRs1     = 1'b1;
        ctrl.useImm     = 1'b0;
        ctrl.isJump     = 1'b0;
        ctrl.isJumpReg  = 1'b0;
        ctrl.isBranch   = 1'b0;
        ctrl.branchFunc = corePkg::branchFuncE'(funct3);
        ctrl.memRead    = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.regWrite   = 1'b0;
        ctrl.wbSrc      = corePkg::WB_ALU;
        immType         = corePkg::IMM_I;
        case (opcode)
            corePkg::OPC_OP: begin
                ctrl.aluOp    = aluOpFor(funct3, funct7b5);
                ctrl.regWrite = 1'b1;
            end
            corePkg::OPC_OP_IMM: begin
                ctrl.aluOp    = aluOpFor(funct3, (funct3 == 3'b101) && funct7b5);  // Only SRAI
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            corePkg::OPC_LUI: begin
                ctrl.aluOp    = corePkg::ALU_COPY2;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                immType       = corePkg::IMM_U;
            end
            corePkg::OPC_AUIPC: begin
                ctrl.useRs1   = 1'b0;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                immType       = corePkg::IMM_U;
            end
            corePkg::OPC_JAL: begin
                ctrl.isJump   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSrc    = corePkg::WB_PC4;
                immType       = corePkg::IMM_J;
            end
            corePkg::OPC_JALR: begin
                ctrl.isJumpReg = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.wbSrc     = corePkg::WB_PC4;
            end
            corePkg::OPC_BRANCH: begin
                ctrl.isBranch = 1'b1;
                immType       = corePkg::IMM_B;
            end
            corePkg::OPC_LOAD: begin
                if (funct3 == 3'b010) begin  // LW only
                    ctrl.useImm   = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.wbSrc    = corePkg::WB_MEM;
                end
            end
            corePkg::OPC_STORE: begin
                immType = corePkg::IMM_S;
                if (funct3 == 3'b010) begin  // SW only
                    ctrl.useImm   = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
            end
            default: ;  // Unknown opcode is a no-op
        endcase
    end

    always_comb begin
        case (immType)
            corePkg::IMM_S: ctrl.imm = {{20{instruction[31]}}, instruction[31:25],
                                        instruction[11:7]};
            corePkg::IMM_B: ctrl.imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                                        instruction[30:25], instruction[11:8], 1'b0};
            corePkg::IMM_U: ctrl.imm = {instruction[31:12], 12'b0};
            corePkg::IMM_J: ctrl.imm = {{11{instruction[31]}}, instruction[31],
                                        instruction[19:12], instruction[20],
                                        instruction[30:21], 1'b0};
            default:        ctrl.imm = {{20{instruction[31]}}, instruction[31:20]};
        endcase
    end

endmodule

// ==== rtl/executeUnit.sv ====
// ALU, branch condition evaluation and next PC selection
`timescale 1ns/100ps

module executeUnit (
    input  corePkg::wordT pc,
    input  corePkg::wordT pcPlus4,
    ctrlIf.exec           ctrl,
    output corePkg::wordT aluResult,
    output corePkg::wordT nextPc
);

    corePkg::wordT aluA;
    corePkg::wordT aluB;
    corePkg::wordT jumpTarget;
    corePkg::wordT jalrTarget;
    logic [4:0]    shamt;
    logic          isEq;
    logic          isLt;
    logic          isLtu;
    logic          taken;

    assign aluA  = ctrl.useRs1 ? ctrl.rs1Data : pc;
    assign aluB  = ctrl.useImm ? ctrl.imm : ctrl.rs2Data;
    assign shamt = aluB[4:0];

    always_comb begin
        case (ctrl.aluOp)
            corePkg::ALU_ADD:   aluResult = aluA + aluB;
            corePkg::ALU_SUB:   aluResult = aluA - aluB;
            corePkg::ALU_AND:   aluResult = aluA & aluB;
            corePkg::ALU_OR:    aluResult = aluA | aluB;
            corePkg::ALU_XOR:   aluResult = aluA ^ aluB;
            corePkg::ALU_SLT:   aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
            corePkg::ALU_SLTU:  aluResult = {31'b0, aluA < aluB};
            corePkg::ALU_SLL:   aluResult = aluA << shamt;
            corePkg::ALU_SRL:   aluResult = aluA >> shamt;
            corePkg::ALU_SRA:   aluResult = $unsigned($signed(aluA) >>> shamt);
            corePkg::ALU_COPY2: aluResult = aluB;
            default:            aluResult = '0;
        endcase
    end

    // Branch compare always on the register operands
    assign isEq  = ctrl.rs1Data == ctrl.rs2Data;
    assign isLt  = $signed(ctrl.rs1Data) < $signed(ctrl.rs2Data);
    assign isLtu = ctrl.rs1Data < ctrl.rs2Data;

    always_comb begin
        case (ctrl.branchFunc)
            corePkg::BR_BEQ:  taken = isEq;
            corePkg::BR_BNE:  taken = !isEq;
            corePkg::BR_BLT:  taken = isLt;
            corePkg::BR_BGE:  taken = !isLt;
            corePkg::BR_BLTU: taken = isLtu;
            corePkg::BR_BGEU: taken = !isLtu;
            default:          taken = 1'b0;
        endcase
    end

    assign jumpTarget = pc + ctrl.imm;
    assign jalrTarget = ctrl.rs1Data + ctrl.imm;

    always_comb begin
        if (ctrl.isJump || (ctrl.isBranch && taken)) begin
            nextPc = jumpTarget;
        end else if (ctrl.isJumpReg) begin
            nextPc = {jalrTarget[31:1], 1'b0};  // Bit 0 cleared per spec
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

// ==== rtl/fetchUnit.sv ====
// Program counter, instruction memory with reset-time load port, PC increment
`timescale 1ns/100ps

module fetchUnit (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            imemWrEn,
    input  logic [corePkg::IMEM_ADDR_W-1:0] imemWrAddr,
    input  corePkg::wordT                   imemWrData,
    input  corePkg::wordT                   nextPc,
    output corePkg::wordT                   pc,
    output corePkg::wordT                   pcPlus4,
    output corePkg::wordT                   instruction
);

    corePkg::wordT imem [corePkg::IMEM_DEPTH];

    logic [corePkg::IMEM_ADDR_W-1:0] pcIdx;

    // Program is loaded only while the core is held in reset
    always_ff @(posedge CLK) begin
        if (RESET && imemWrEn) begin
            imem[imemWrAddr] <= imemWrData;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc <= corePkg::RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    assign pcIdx       = pc[corePkg::IMEM_ADDR_W+1:2];  // Word index
    assign instruction = imem[pcIdx];
    assign pcPlus4     = pc + 32'd4;

endmodule

// ==== rtl/memStage.sv ====
// Word data memory, print port and writeback source select
`timescale 1ns/100ps

module memStage (
    input  logic          CLK,
    input  logic          RESET,
    input  corePkg::wordT aluResult,
    input  corePkg::wordT pcPlus4,
    ctrlIf.mem            ctrl,
    output corePkg::wordT wbData,
    output corePkg::wordT printVal,
    output logic          printEn
);

    corePkg::wordT dmem [corePkg::DMEM_DEPTH];

    logic [corePkg::DMEM_ADDR_W-1:0] dmemIdx;
    logic                            isPrint;
    corePkg::wordT                   readData;

    assign dmemIdx = aluResult[corePkg::DMEM_ADDR_W+1:2];
    assign isPrint = aluResult == corePkg::PRINT_ADDR;  // Full byte address compare

    always_ff @(posedge CLK) begin
        if (!RESET && ctrl.memWrite && !isPrint) begin
            dmem[dmemIdx] <= ctrl.rs2Data;
        end
    end

    assign readData = ctrl.memRead ? dmem[dmemIdx] : '0;
    assign printVal = ctrl.rs2Data;
    assign printEn  = ctrl.memWrite && isPrint && !RESET;

    always_comb begin
        case (ctrl.wbSrc)
            corePkg::WB_MEM: wbData = readData;
            corePkg::WB_PC4: wbData = pcPlus4;  // Link address
            default:         wbData = aluResult;
        endcase
    end

endmodule

// ==== rtl/regFile.sv ====
// General register file, x1 to x31, with x0 read as zero
`timescale 1ns/100ps

module regFile (
    input  logic             CLK,
    input  logic             RESET,
    input  corePkg::regAddrT rs1Addr,
    input  corePkg::regAddrT rs2Addr,
    input  corePkg::regAddrT rdAddr,
    input  corePkg::wordT    wbData,
    ctrlIf.decode            ctrl
);

    corePkg::wordT regs [1:31];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && (rdAddr != '0)) begin
            regs[rdAddr] <= wbData;
        end
    end

    assign ctrl.rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign ctrl.rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== tests/coreTb.sv ====
// Testbench for the core: program load in reset, print value and print count checks
`timescale 1ns/100ps

module coreTb;

    localparam int FILE_DEPTH   = 512;
    localparam int RESET_CYCLES = 8;

    logic                            CLK;
    logic                            RESET;
    logic                            imemWrEn;
    logic [corePkg::IMEM_ADDR_W-1:0] imemWrAddr;
    corePkg::wordT                   imemWrData;
    corePkg::wordT                   printVal;
    logic                            printEn;

    corePkg::wordT fileData [FILE_DEPTH];
    corePkg::wordT expected [$];
    int            wordCount;
    int            printCount;
    int            printsSeen  = 0;
    int            valueErrors = 0;
    int            countErrors = 0;
    int            otherErrors = 0;
    int            cycles      = 0;
    int            cycleLimit;
    bit            running     = 1'b0;

    core DUT (
        .CLK        (CLK),
        .RESET      (RESET),
        .imemWrEn   (imemWrEn),
        .imemWrAddr (imemWrAddr),
        .imemWrData (imemWrData),
        .printVal   (printVal),
        .printEn    (printEn)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic checkWord(input string name, input corePkg::wordT exp,
                             input corePkg::wordT act);
        if (act !== exp) begin
            valueErrors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            countErrors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Print monitor, also counts cycles once the core runs
    always @(posedge CLK) begin
        if (running) begin
            cycles++;
        end
        if (printEn === 1'b1) begin
            if (printsSeen < expected.size()) begin
                checkWord($sformatf("print %0d", printsSeen), expected[printsSeen], printVal);
            end else begin
                otherErrors++;
                $display("Print of %h came after all expected prints were seen", printVal);
            end
            printsSeen++;
        end
    end

    initial begin
        int assertErrors;
        RESET      = 1'b1;
        imemWrEn   = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        $readmemh("tests/core_input.txt", fileData);
        wordCount  = fileData[0];
        printCount = fileData[wordCount + 1];
        if (wordCount < 1 || wordCount > corePkg::IMEM_DEPTH ||
            wordCount + printCount + 2 > FILE_DEPTH) begin
            otherErrors++;
            $display("Input file has no usable program or print list");
            wordCount  = 0;
            printCount = 0;
        end
        for (int i = 0; i < printCount; i++) begin
            expected.push_back(fileData[wordCount + 2 + i]);
        end
        cycleLimit = RESET_CYCLES + 4 * wordCount;

        for (int i = 0; i < wordCount; i++) begin
            @(negedge CLK);
            imemWrEn   = 1'b1;
            imemWrAddr = i[corePkg::IMEM_ADDR_W-1:0];
            imemWrData = fileData[i + 1];
        end
        @(negedge CLK);
        imemWrEn = 1'b0;
        repeat (RESET_CYCLES - 1) @(negedge CLK);  // Reset held 8 cycles past the load
        RESET   = 1'b0;
        running = 1'b1;

        // Program parks in a self loop well before the limit
        while (cycles < cycleLimit) @(negedge CLK);
        checkCount("print count", printCount, printsSeen);

        assertErrors = DUT.uAsserts.failCount;
        $display("Errors: %0d value, %0d count, %0d other, %0d assertion",
                 valueErrors, countErrors, otherErrors, assertErrors);
        if (valueErrors + countErrors + otherErrors + assertErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/core_assertions.sv ====
// Bound checks on the core: print strobe in reset, known print value, PC alignment
`timescale 1ns/100ps

module coreAssertions (
    input logic          CLK,
    input logic          RESET,
    input logic          printEn,
    input corePkg::wordT printVal,
    input corePkg::wordT pc
);

    int failCount = 0;  // Failed assertions so far

    printQuietInReset: assert property (@(posedge CLK) RESET |-> !printEn)
        else begin
            failCount++;
            $error("printEn is high while RESET is asserted");
        end

    printValKnown: assert property (@(posedge CLK) printEn |-> !$isunknown(printVal))
        else begin
            failCount++;
            $error("printVal holds X or Z bits while printEn is high");
        end

    pcAligned: assert property (@(posedge CLK) disable iff (RESET) pc[1:0] == 2'b00)
        else begin
            failCount++;
            $error("PC is not word aligned");
        end

endmodule

bind core coreAssertions uAsserts (
    .CLK      (CLK),
    .RESET    (RESET),
    .printEn  (printEn),
    .printVal (printVal),
    .pc       (pc)
);

// ==== tests/core_input.txt ====
// Hex words: program word count, program words, print count, expected print values in order
// Each print is SW rs2,0x30(x31) to byte address 0x1030; asm of each group at line end
0000003F
00001FB7 00700093 FFD00113 002081B3  // lui x31,1; addi x1,7; addi x2,-3; add x3,x1,x2
023FA823 40208233 024FA823 001122B3  // print x3; sub x4,x1,x2; print x4; slt x5,x2,x1
00113333 025FA823 026FA823 40115393  // sltu x6,x2,x1; print x5; print x6; srai x7,x2,1
00115413 027FA823 028FA823 0020C4B3  // srli x8,x2,1; print x7; print x8; xor x9,x1,x2
029FA823 ABCDE537 02AFA823 00002597  // print x9; lui x10; print x10; auipc x11,2 at 0x4c
02BFA823                             // print x11
00108463 022FA823 00208463 021FA823  // beq taken over print x2, not taken over print x1
00209463 022FA823 00109463 021FA823  // bne
00114463 022FA823 0020C463 021FA823  // blt
0020D463 022FA823 00115463 021FA823  // bge
0020E463 022FA823 00116463 021FA823  // bltu
00117463 022FA823 0020F463 021FA823  // bgeu
00000613 00500693 00160613 FED61EE3  // x12=0; x13=5; loop x12++; bne x12,x13 back
02CFA823                             // print x12
0080076F 022FA823 02EFA823           // jal x14,+8 at 0xc8; skipped print; print x14
00000797 00D78867 022FA823 030FA823  // auipc x15 at 0xd4; jalr x16,13(x15); skipped; print
00A02823 01002883 031FA823           // sw x10,16(x0); lw x17,16(x0); print x17
00508013 020FA823 0000006F           // addi x0,x1,5; print x0; jal x0,0
00000014
00000004 0000000A 00000001 00000000  // add, sub, slt, sltu
FFFFFFFE 7FFFFFFE FFFFFFFA           // srai, srli, xor
ABCDE000 0000204C                    // lui, auipc
00000007 00000007 00000007 00000007  // not-taken branch prints
00000007 00000007
00000005 000000CC 000000DC           // loop count, jal link, jalr link
ABCDE000 00000000                    // loaded word, x0
